// ==== flist.f ====
logic/video_pkg.sv
logic/host_pkg.sv
logic/video_ifs.sv
logic/video_timer.sv
logic/tile_layer.sv
logic/color_mixer.sv
logic/tile_video_top.sv
sim/tile_video_props.sv
sim/tile_video_tb.sv

// ==== logic/color_mixer.sv ====
`timescale 1ns/100ps
`default_nettype none

// Layer priority, palette lookup and blanking
module color_mixer #(
	parameter int NUM_LAYERS = 3
) (
	input logic clk,
	input logic rst,
	video_timing_if.sink timing,
	host_wr_if.slave host,
	input video_pkg::layer_pixel_t pixels [NUM_LAYERS],
	output logic [3:0] red,
	output logic [3:0] green,
	output logic [3:0] blue,
	output logic lhbl_out,
	output logic lvbl_out
);

	localparam int LB = host_pkg::LAYER_BITS;
	localparam int ENTRY_BITS = LB + video_pkg::PAL_BITS + video_pkg::COLOR_BITS;
	localparam int PAL_DEPTH = 2**ENTRY_BITS;

	// Palette stored as two halves, matching the host write layout
	logic [7:0] rg_mem [PAL_DEPTH];
	logic [3:0] b_mem [PAL_DEPTH];

	logic [host_pkg::OFFSET_BITS-1:0] ofs;
	logic [ENTRY_BITS-1:0] wr_entry;
	logic wr_pal;

	logic [ENTRY_BITS-1:0] pal_idx;
	video_pkg::rgb_t pal_rgb;

	// Blanking levels, two cycles behind the timer to match the layers
	logic [1:0] lhbl_d;
	logic [1:0] lvbl_d;
	logic visible;

	assign ofs      = host_pkg::offset_of(host.addr);
	assign wr_entry = ofs[host_pkg::PAL_OFS_BITS-1:1];
	assign wr_pal   = host.we && host_pkg::region_of(host.addr) == host_pkg::REG_PALETTE;

	always_ff @(posedge clk) begin
		if (wr_pal) begin
			if (ofs[0]) begin
				b_mem[wr_entry] <= host.data[3:0];
			end else begin
				rg_mem[wr_entry] <= host.data;	// Red high nibble, green low
			end
		end
	end

	// Topmost opaque layer wins, entry 0 is the backdrop
	always_comb begin
		pal_idx = '0;
		for (int i = 0; i < NUM_LAYERS; i++) begin
			if (pixels[i].color != '0) begin
				pal_idx = {LB'(i), pixels[i].pal, pixels[i].color};
			end
		end
	end

	always_comb begin
		pal_rgb.r = rg_mem[pal_idx][7:4];
		pal_rgb.g = rg_mem[pal_idx][3:0];
		pal_rgb.b = b_mem[pal_idx];
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			lhbl_d <= '0;
			lvbl_d <= '0;
		end else begin
			lhbl_d <= {lhbl_d[0], timing.lhbl};
			lvbl_d <= {lvbl_d[0], timing.lvbl};
		end
	end

	assign visible = lhbl_d[1] && lvbl_d[1];

	// Third cycle, aligned with the palette read
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			red      <= '0;
			green    <= '0;
			blue     <= '0;
			lhbl_out <= 1'b0;
			lvbl_out <= 1'b0;
		end else begin
			red      <= visible ? pal_rgb.r : 4'h0;
			green    <= visible ? pal_rgb.g : 4'h0;
			blue     <= visible ? pal_rgb.b : 4'h0;
			lhbl_out <= lhbl_d[1];
			lvbl_out <= lvbl_d[1];
		end
	end

endmodule

`default_nettype wire

// ==== logic/host_pkg.sv ====
`default_nettype none

// Host bus address map
package host_pkg;

	localparam int HOST_ADDR_BITS = 16;
	localparam int HOST_DATA_BITS = 8;

	typedef enum logic [1:0] {
		REG_MAP,
		REG_PATTERN,
		REG_SCROLL,
		REG_PALETTE
	} region_e;

	// addr[15:14] region, addr[13:12] layer, addr[11:0] offset
	localparam int REGION_LSB  = 14;
	localparam int LAYER_LSB   = 12;
	localparam int LAYER_BITS  = 2;
	localparam int OFFSET_BITS = 12;

	localparam int MAP_OFS_BITS = 7;	// {tile row, tile column}
	localparam int PAT_OFS_BITS = 8;	// {code, row in tile, pixel quad}
	localparam int PAL_OFS_BITS = 7;	// {entry, half}

	localparam logic [OFFSET_BITS-1:0] SCROLL_X_OFS = 12'd0;
	localparam logic [OFFSET_BITS-1:0] SCROLL_Y_OFS = 12'd1;

	function automatic region_e region_of(input logic [HOST_ADDR_BITS-1:0] addr);
		return region_e'(addr[REGION_LSB +: 2]);
	endfunction

	function automatic logic [LAYER_BITS-1:0] layer_of(input logic [HOST_ADDR_BITS-1:0] addr);
		return addr[LAYER_LSB +: LAYER_BITS];
	endfunction

	function automatic logic [OFFSET_BITS-1:0] offset_of(input logic [HOST_ADDR_BITS-1:0] addr);
		return addr[OFFSET_BITS-1:0];
	endfunction

endpackage

`default_nettype wire

// ==== logic/tile_layer.sv ====
`timescale 1ns/100ps
`default_nettype none

// One scrolled tile plane
// Stage 0 scrolls h/v, stage 1 reads the map, stage 2 reads the pattern
module tile_layer #(
	parameter int LAYER_ID = 0
) (
	input logic clk,
	input logic rst,
	video_timing_if.sink timing,
	host_wr_if.slave host,
	output video_pkg::layer_pixel_t pixel
);

	localparam int PX = video_pkg::PLANE_X_BITS;
	localparam int PY = video_pkg::PLANE_Y_BITS;
	localparam int TB = video_pkg::TILE_BITS;
	localparam int MAP_DEPTH = 2**host_pkg::MAP_OFS_BITS;
	localparam int PAT_DEPTH = 2**host_pkg::PAT_OFS_BITS;

	typedef struct packed {
		logic [video_pkg::PAL_BITS-1:0]  pal;
		logic [video_pkg::CODE_BITS-1:0] code;
	} map_entry_t;

	map_entry_t map_mem [MAP_DEPTH];
	logic [host_pkg::HOST_DATA_BITS-1:0] pat_mem [PAT_DEPTH];

	logic [host_pkg::OFFSET_BITS-1:0] ofs;
	logic layer_hit;
	logic wr_map;
	logic wr_pat;
	logic wr_scroll;

	// Scroll as written by the host, and as held for the current line
	logic [PX-1:0] scroll_x;
	logic [PY-1:0] scroll_y;
	logic [PX-1:0] scroll_x_line;
	logic [PY-1:0] scroll_y_line;

	logic [PX-1:0] sx;
	logic [PY-1:0] sy;
	logic [PX-1:0] plane_x;
	logic [PY-1:0] plane_y;

	map_entry_t map_q;
	logic [TB-1:0] fine_x_q;
	logic [TB-1:0] fine_y_q;

	logic [host_pkg::HOST_DATA_BITS-1:0] pat_byte;
	logic [host_pkg::HOST_DATA_BITS-1:0] pat_shift;

	// Host decode
	assign ofs       = host_pkg::offset_of(host.addr);
	assign layer_hit = host.we &&
		host_pkg::layer_of(host.addr) == host_pkg::LAYER_BITS'(LAYER_ID);
	assign wr_map    = layer_hit && host_pkg::region_of(host.addr) == host_pkg::REG_MAP;
	assign wr_pat    = layer_hit && host_pkg::region_of(host.addr) == host_pkg::REG_PATTERN;
	assign wr_scroll = layer_hit && host_pkg::region_of(host.addr) == host_pkg::REG_SCROLL;

	always_ff @(posedge clk) begin
		if (wr_map) begin
			map_mem[ofs[host_pkg::MAP_OFS_BITS-1:0]] <= map_entry_t'(host.data[5:0]);
		end
		if (wr_pat) begin
			pat_mem[ofs[host_pkg::PAT_OFS_BITS-1:0]] <= host.data;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			scroll_x <= '0;
			scroll_y <= '0;
		end else if (wr_scroll) begin
			if (ofs == host_pkg::SCROLL_X_OFS) scroll_x <= host.data[PX-1:0];
			if (ofs == host_pkg::SCROLL_Y_OFS) scroll_y <= host.data[PY-1:0];
		end
	end

	// Scroll is sampled at the start of each line
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			scroll_x_line <= '0;
			scroll_y_line <= '0;
		end else if (timing.hinit) begin
			scroll_x_line <= scroll_x;
			scroll_y_line <= scroll_y;
		end
	end

	assign sx = timing.hinit ? scroll_x : scroll_x_line;
	assign sy = timing.hinit ? scroll_y : scroll_y_line;

	// Stage 0, wraps in the 128 x 64 plane
	assign plane_x = timing.h[PX-1:0] + sx;
	assign plane_y = timing.v[PY-1:0] + sy;

	// Stage 1, map entry for {tile row, tile column}
	always_ff @(posedge clk) begin
		map_q    <= map_mem[{plane_y[PY-1:TB], plane_x[PX-1:TB]}];
		fine_x_q <= plane_x[TB-1:0];
		fine_y_q <= plane_y[TB-1:0];
	end

	// Leftmost pixel of a quad sits in bits 7-6
	assign pat_byte  = pat_mem[{map_q.code, fine_y_q, fine_x_q[TB-1]}];
	assign pat_shift = pat_byte << {fine_x_q[1:0], 1'b0};

	// Stage 2
	always_ff @(posedge clk) begin
		pixel.color <= pat_shift[7 -: video_pkg::COLOR_BITS];
		pixel.pal   <= map_q.pal;
	end

endmodule

`default_nettype wire

// ==== logic/tile_video_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module tile_video_top #(
	parameter int NUM_LAYERS = 3,
	parameter int H_ACTIVE   = video_pkg::H_ACTIVE_DEF,
	parameter int H_TOTAL    = video_pkg::H_TOTAL_DEF,
	parameter int V_ACTIVE   = video_pkg::V_ACTIVE_DEF,
	parameter int V_TOTAL    = video_pkg::V_TOTAL_DEF
) (
	input logic clk,
	input logic rst,
	input logic [15:0] host_addr,
	input logic [7:0] host_data,
	input logic host_we,
	output logic [3:0] red,
	output logic [3:0] green,
	output logic [3:0] blue,
	output logic lhbl,
	output logic lvbl
);

	video_timing_if timing ();
	host_wr_if host_bus ();

	video_pkg::layer_pixel_t layer_px [NUM_LAYERS];

	// Host port onto the internal write bus
	assign host_bus.addr = host_addr;
	assign host_bus.data = host_data;
	assign host_bus.we   = host_we;

	video_timer #(
		.H_ACTIVE (H_ACTIVE),
		.H_TOTAL  (H_TOTAL),
		.V_ACTIVE (V_ACTIVE),
		.V_TOTAL  (V_TOTAL)
	) i_timer (
		.clk    (clk),
		.rst    (rst),
		.timing (timing)
	);

	for (genvar i = 0; i < NUM_LAYERS; i++) begin : g_layer
		tile_layer #(
			.LAYER_ID (i)
		) i_layer (
			.clk    (clk),
			.rst    (rst),
			.timing (timing),
			.host   (host_bus),
			.pixel  (layer_px[i])
		);
	end

	color_mixer #(
		.NUM_LAYERS (NUM_LAYERS)
	) i_mixer (
		.clk      (clk),
		.rst      (rst),
		.timing   (timing),
		.host     (host_bus),
		.pixels   (layer_px),
		.red      (red),
		.green    (green),
		.blue     (blue),
		.lhbl_out (lhbl),	// Three cycles behind the timer
		.lvbl_out (lvbl)
	);

endmodule

`default_nettype wire

// ==== logic/video_ifs.sv ====
`timescale 1ns/100ps
`default_nettype none

// Screen position and blanking from the video timer
interface video_timing_if;
	logic [video_pkg::CNT_BITS-1:0] h;
	logic [video_pkg::CNT_BITS-1:0] v;
	logic lhbl;	// High while inside the active part of a line
	logic lvbl;	// High while inside the active lines
	logic hinit;	// Single cycle at h == 0

	modport source (
		output h,
		output v,
		output lhbl,
		output lvbl,
		output hinit
	);

	modport sink (
		input h,
		input v,
		input lhbl,
		input lvbl,
		input hinit
	);
endinterface

// Host write strobes, no acknowledge
interface host_wr_if;
	logic [host_pkg::HOST_ADDR_BITS-1:0] addr;
	logic [host_pkg::HOST_DATA_BITS-1:0] data;
	logic we;

	modport master (
		output addr,
		output data,
		output we
	);

	modport slave (
		input addr,
		input data,
		input we
	);
endinterface

`default_nettype wire

// ==== logic/video_pkg.sv ====
`default_nettype none

// Screen geometry and the pixel formats shared by the video blocks
package video_pkg;

	// Default screen geometry, in pixels and lines
	localparam int H_ACTIVE_DEF = 64;
	localparam int H_TOTAL_DEF  = 80;
	localparam int V_ACTIVE_DEF = 32;
	localparam int V_TOTAL_DEF  = 40;

	// Width of the h and v counters
	localparam int CNT_BITS = 9;

	// Tiles are 2**TILE_BITS pixels square
	localparam int TILE_BITS = 3;

	// Map is 16 x 8 tiles, so the plane is 128 x 64 pixels and wraps
	localparam int MAP_W_BITS = 4;
	localparam int MAP_H_BITS = 3;
	localparam int PLANE_X_BITS = MAP_W_BITS + TILE_BITS;
	localparam int PLANE_Y_BITS = MAP_H_BITS + TILE_BITS;

	localparam int CODE_BITS  = 4;	// 16 tile codes per layer
	localparam int COLOR_BITS = 2;	// Colour 0 is transparent
	localparam int PAL_BITS   = 2;	// Palette select per tile

	// One layer's output for a single screen position
	typedef struct packed {
		logic [COLOR_BITS-1:0] color;
		logic [PAL_BITS-1:0]   pal;
	} layer_pixel_t;

	// 4-bit per gun colour as stored in the palette
	typedef struct packed {
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
	} rgb_t;

endpackage

`default_nettype wire

// ==== logic/video_timer.sv ====
`timescale 1ns/100ps
`default_nettype none

module video_timer #(
	parameter int H_ACTIVE = video_pkg::H_ACTIVE_DEF,
	parameter int H_TOTAL  = video_pkg::H_TOTAL_DEF,
	parameter int V_ACTIVE = video_pkg::V_ACTIVE_DEF,
	parameter int V_TOTAL  = video_pkg::V_TOTAL_DEF
) (
	input logic clk,
	input logic rst,
	video_timing_if.source timing
);

	localparam int CW = video_pkg::CNT_BITS;

	localparam logic [CW-1:0] H_LAST = CW'(H_TOTAL - 1);
	localparam logic [CW-1:0] V_LAST = CW'(V_TOTAL - 1);
	localparam logic [CW-1:0] H_VIS  = CW'(H_ACTIVE);
	localparam logic [CW-1:0] V_VIS  = CW'(V_ACTIVE);

	logic [CW-1:0] h;
	logic [CW-1:0] v;
	logic line_end;

	assign line_end = h == H_LAST;

	// Pixel counter
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			h <= '0;
		end else if (line_end) begin
			h <= '0;
		end else begin
			h <= h + 1'b1;
		end
	end

	// Line counter, advances once per line
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			v <= '0;
		end else if (line_end) begin
			if (v == V_LAST) begin
				v <= '0;
			end else begin
				v <= v + 1'b1;
			end
		end
	end

	assign timing.h     = h;
	assign timing.v     = v;
	assign timing.lhbl  = h < H_VIS;
	assign timing.lvbl  = v < V_VIS;
	assign timing.hinit = h == '0;	// Line start pulse

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and search the output for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timescale 1ns/100ps --top-module tile_video_tb \
	-f flist.f -o tile_video_sim || exit 1
out=$(./obj_dir/tile_video_sim +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -qF '*** TEST PASSED ***' && echo "Simulation passed" || {
	echo "Simulation failed"
	exit 1
}

// ==== sim/tile_video_props.sv ====
`timescale 1ns/100ps
`default_nettype none

// Blanking and frame-geometry checks on the top-level video outputs
module tile_video_props #(
	parameter int H_ACTIVE = video_pkg::H_ACTIVE_DEF,
	parameter int H_TOTAL  = video_pkg::H_TOTAL_DEF,
	parameter int V_ACTIVE = video_pkg::V_ACTIVE_DEF,
	parameter int V_TOTAL  = video_pkg::V_TOTAL_DEF
) (
	input logic clk,
	input logic rst,
	input logic [3:0] red,
	input logic [3:0] green,
	input logic [3:0] blue,
	input logic lhbl,
	input logic lvbl
);

	logic lhbl_prev;
	logic lvbl_prev;
	logic line_start;
	logic frame_start;
	logic line_seen;	// A full line has begun since reset
	logic frame_seen;
	int line_cycles;
	int line_active;
	int frame_lines;
	int frame_active;
	int blank_fails = 0;
	int line_fails = 0;
	int frame_fails = 0;

	assign line_start  = lhbl && !lhbl_prev;
	assign frame_start = lvbl && !lvbl_prev;	// Always lands on a line start

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			lhbl_prev    <= 1'b0;
			lvbl_prev    <= 1'b0;
			line_seen    <= 1'b0;
			frame_seen   <= 1'b0;
			line_cycles  <= 0;
			line_active  <= 0;
			frame_lines  <= 0;
			frame_active <= 0;
		end else begin
			lhbl_prev <= lhbl;
			lvbl_prev <= lvbl;
			if (line_start) begin
				line_seen   <= 1'b1;
				line_cycles <= 1;
				line_active <= 1;
			end else begin
				line_cycles <= line_cycles + 1;
				if (lhbl) line_active <= line_active + 1;
			end
			if (frame_start) begin
				frame_seen   <= 1'b1;
				frame_lines  <= 1;
				frame_active <= 1;
			end else if (line_start) begin
				frame_lines <= frame_lines + 1;
				if (lvbl) frame_active <= frame_active + 1;
			end
		end
	end

	blank_black: assert property (@(posedge clk) disable iff (rst)
		!(lhbl && lvbl) |-> red == 4'h0 && green == 4'h0 && blue == 4'h0)
	else begin
		$error("RGB output is not black during blanking");
		blank_fails++;
	end

	// Counts cover the line that just ended
	line_length: assert property (@(posedge clk) disable iff (rst)
		line_start && line_seen |-> line_cycles == H_TOTAL && line_active == H_ACTIVE)
	else begin
		$error("Line length or active width is wrong");
		line_fails++;
	end

	frame_length: assert property (@(posedge clk) disable iff (rst)
		frame_start && frame_seen |-> frame_lines == V_TOTAL && frame_active == V_ACTIVE)
	else begin
		$error("Frame length or active height is wrong");
		frame_fails++;
	end

endmodule

`default_nettype wire

// ==== sim/tile_video_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module tile_video_tb;

	localparam int NUM_LAYERS   = 3;
	localparam int H_ACTIVE     = video_pkg::H_ACTIVE_DEF;
	localparam int H_TOTAL      = video_pkg::H_TOTAL_DEF;
	localparam int V_ACTIVE     = video_pkg::V_ACTIVE_DEF;
	localparam int V_TOTAL      = video_pkg::V_TOTAL_DEF;
	localparam int CLK_PERIOD   = 100;
	localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
	localparam int NUM_FRAMES   = 3;

	// Full fill, scroll update after frame 1, palette update after frame 2
	localparam int NUM_WRITES = NUM_LAYERS * (128 + 256 + 2) + 2 * 64 + 2 * NUM_LAYERS + 2;
	localparam int TIMEOUT_CYCLES = NUM_WRITES + 4 * FRAME_CYCLES + FRAME_CYCLES;

	logic clk = 1'b0;
	logic rst;
	logic [15:0] host_addr;
	logic [7:0] host_data;
	logic host_we;
	logic [3:0] red;
	logic [3:0] green;
	logic [3:0] blue;
	logic lhbl;
	logic lvbl;

	logic [31:0] lcg_state = 32'hd9e;

	// Model of everything the host has written
	logic [7:0] map_model [NUM_LAYERS][128];
	logic [7:0] pat_model [NUM_LAYERS][256];
	logic [7:0] scroll_x_model [NUM_LAYERS];
	logic [7:0] scroll_y_model [NUM_LAYERS];
	logic [7:0] rg_model [64];
	logic [3:0] b_model [64];

	logic checking = 1'b0;
	logic lhbl_prev = 1'b0;
	logic lvbl_prev = 1'b0;
	int x_pos = 0;
	int y_pos = 0;
	int errors = 0;
	int prop_fails;
	int pixels_checked = 0;

	tile_video_top #(
		.NUM_LAYERS (NUM_LAYERS),
		.H_ACTIVE   (H_ACTIVE),
		.H_TOTAL    (H_TOTAL),
		.V_ACTIVE   (V_ACTIVE),
		.V_TOTAL    (V_TOTAL)
	) i_dut (
		.clk       (clk),
		.rst       (rst),
		.host_addr (host_addr),
		.host_data (host_data),
		.host_we   (host_we),
		.red       (red),
		.green     (green),
		.blue      (blue),
		.lhbl      (lhbl),
		.lvbl      (lvbl)
	);

	bind tile_video_top tile_video_props #(
		.H_ACTIVE (H_ACTIVE),
		.H_TOTAL  (H_TOTAL),
		.V_ACTIVE (V_ACTIVE),
		.V_TOTAL  (V_TOTAL)
	) i_props (
		.clk   (clk),
		.rst   (rst),
		.red   (red),
		.green (green),
		.blue  (blue),
		.lhbl  (lhbl),
		.lvbl  (lvbl)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [7:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:24];	// Upper bits are the most random
	endfunction

	task automatic host_write(input logic [15:0] addr, input logic [7:0] data);
		@(posedge clk);
		#1;
		host_addr = addr;
		host_data = data;
		host_we   = 1'b1;
	endtask

	task automatic host_idle();
		@(posedge clk);
		#1;
		host_we = 1'b0;
	endtask

	task automatic write_map(input logic [1:0] layer, input logic [6:0] idx,
			input logic [7:0] data);
		host_write({host_pkg::REG_MAP, layer, 5'd0, idx}, data);
		map_model[layer][idx] = data;
	endtask

	task automatic write_pattern(input logic [1:0] layer, input logic [7:0] idx,
			input logic [7:0] data);
		host_write({host_pkg::REG_PATTERN, layer, 4'd0, idx}, data);
		pat_model[layer][idx] = data;
	endtask

	task automatic write_scroll(input logic [1:0] layer, input logic axis, input logic [7:0] data);
		host_write({host_pkg::REG_SCROLL, layer, 11'd0, axis}, data);
		if (axis) scroll_y_model[layer] = data;
		else scroll_x_model[layer] = data;
	endtask

	// Half 0 carries red and green, half 1 carries blue
	task automatic write_palette(input logic [5:0] entry, input logic half, input logic [7:0] data);
		host_write({host_pkg::REG_PALETTE, 2'd0, 5'd0, entry, half}, data);
		if (half) b_model[entry] = data[3:0];
		else rg_model[entry] = data;
	endtask

	task automatic fill_memories();
		for (int l = 0; l < NUM_LAYERS; l++) begin
			for (int i = 0; i < 128; i++) begin
				write_map(2'(l), 7'(i), lcg_next());
			end
			for (int i = 0; i < 256; i++) begin
				write_pattern(2'(l), 8'(i), lcg_next());
			end
			write_scroll(2'(l), 1'b0, lcg_next());
			write_scroll(2'(l), 1'b1, lcg_next());
		end
		for (int e = 0; e < 64; e++) begin
			write_palette(6'(e), 1'b0, lcg_next());
			write_palette(6'(e), 1'b1, lcg_next());
		end
	endtask

	// Expected {r, g, b} at screen position (x, y) from the model
	function automatic logic [11:0] expected_rgb(input int x, input int y);
		int px;
		int py;
		logic [1:0] lyr;
		logic [7:0] map_byte;
		logic [7:0] pat_byte;
		logic [7:0] shifted;
		logic [5:0] entry;
		entry = 6'd0;	// Backdrop when every layer is transparent
		for (int l = 0; l < NUM_LAYERS; l++) begin
			lyr = 2'(l);
			px = (x + int'(scroll_x_model[lyr])) % 128;
			py = (y + int'(scroll_y_model[lyr])) % 64;
			map_byte = map_model[lyr][7'((py / 8) * 16 + px / 8)];
			pat_byte = pat_model[lyr][8'(int'(map_byte[3:0]) * 16 + (py % 8) * 2 + (px % 8) / 4)];
			shifted = pat_byte << (2 * (px % 4));	// Leftmost pixel in bits 7-6
			if (shifted[7:6] != 2'd0) begin
				entry = {lyr, map_byte[5:4], shifted[7:6]};
			end
		end
		return {rg_model[entry], b_model[entry]};
	endfunction

	task automatic check_pixel(input int x, input int y);
		logic [11:0] exp_rgb;
		exp_rgb = expected_rgb(x, y);
		pixels_checked++;
		assert (red == exp_rgb[11:8]) else begin
			$display("ERROR red at (%0d,%0d): expected %h, got %h", x, y, exp_rgb[11:8], red);
			errors++;
		end
		assert (green == exp_rgb[7:4]) else begin
			$display("ERROR green at (%0d,%0d): expected %h, got %h", x, y, exp_rgb[7:4], green);
			errors++;
		end
		assert (blue == exp_rgb[3:0]) else begin
			$display("ERROR blue at (%0d,%0d): expected %h, got %h", x, y, exp_rgb[3:0], blue);
			errors++;
		end
	endtask

	// Screen position follows the rising edges of the delayed blanking levels
	always @(negedge clk) begin
		if (lhbl && !lhbl_prev) begin
			x_pos = 0;
			y_pos = (lvbl && !lvbl_prev) ? 0 : y_pos + 1;
		end else begin
			x_pos = x_pos + 1;
		end
		lhbl_prev = lhbl;
		lvbl_prev = lvbl;
		if (checking && lhbl && lvbl) begin
			check_pixel(x_pos, y_pos);
		end
	end

	initial begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("Watchdog expired before the last frame was rendered");
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		rst       = 1'b1;
		host_addr = 16'h0000;
		host_data = 8'h00;
		host_we   = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		fill_memories();
		host_idle();
		@(negedge lvbl);	// Start checking from a clean frame
		checking = 1'b1;
		for (int f = 0; f < NUM_FRAMES; f++) begin
			@(posedge lvbl);
			@(negedge lvbl);
			if (f == 0) begin
				for (int l = 0; l < NUM_LAYERS; l++) begin
					write_scroll(2'(l), 1'b0, lcg_next());
					write_scroll(2'(l), 1'b1, lcg_next());
				end
			end else if (f == 1) begin
				write_palette(6'd0, 1'b0, lcg_next());	// Backdrop gets new red and green only
				// Layer 2 entry with an opaque colour
				write_palette(6'(32 + 4 * int'(lcg_next() % 8'd4) + 1 + int'(lcg_next() % 8'd3)),
					1'b0, lcg_next());
			end
			host_idle();
		end
		checking = 1'b0;
		prop_fails = i_dut.i_props.blank_fails + i_dut.i_props.line_fails +
			i_dut.i_props.frame_fails;
		$display("Checked %0d of %0d pixels, %0d pixel errors, %0d property failures",
			pixels_checked, NUM_FRAMES * H_ACTIVE * V_ACTIVE, errors, prop_fails);
		if (errors == 0 && prop_fails == 0 &&
				pixels_checked == NUM_FRAMES * H_ACTIVE * V_ACTIVE) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire
